// ==== source/jogo_ritmo_pkg.sv ====
`default_nettype none

package jogo_ritmo_pkg;

    // Nota tocada, um botao e um LED por codigo
    typedef logic [1:0] nota_t;

    // Duracao em batidas, a musica usa 1 ou 2
    typedef logic [1:0] duracao_t;

    // Estados do controle
    typedef enum logic [3:0] {
        e_inicial        = 4'h0,
        e_preparacao     = 4'h1,
        e_inicia_rodada  = 4'h2,
        e_mostra_nota    = 4'h3,
        e_intervalo      = 4'h4,
        e_proxima_mostra = 4'h5,
        e_inicia_jogada  = 4'h6,
        e_espera_jogada  = 4'h7,
        e_compara        = 4'h8,
        e_proxima_jogada = 4'h9,
        e_erro           = 4'ha,
        e_proxima_rodada = 4'hb,
        e_ganhou         = 4'hc,
        e_perdeu         = 4'hd
    } estado_t;

    // Largura do digito dos displays
    localparam int LARGURA_HEXA = 4;

endpackage

`default_nettype wire

// ==== source/hexa7seg.sv ====
`timescale 1ns/100ps
`default_nettype none

module hexa7seg import jogo_ritmo_pkg::*; (
    input  logic [LARGURA_HEXA-1:0] hexa,
    output logic [6:0]              display
);

    // Segmentos gfedcba, ativos em baixo
    always_comb begin
        case (hexa)
            4'h0:    display = 7'b1000000;
            4'h1:    display = 7'b1111001;
            4'h2:    display = 7'b0100100;
            4'h3:    display = 7'b0110000;
            4'h4:    display = 7'b0011001;
            4'h5:    display = 7'b0010010;
            4'h6:    display = 7'b0000010;
            4'h7:    display = 7'b1111000;
            4'h8:    display = 7'b0000000;
            4'h9:    display = 7'b0010000;
            4'ha:    display = 7'b0001000;
            4'hb:    display = 7'b0000011;
            4'hc:    display = 7'b1000110;
            4'hd:    display = 7'b0100001;
            4'he:    display = 7'b0000110;
            default: display = 7'b0001110;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/temporizador_nota.sv ====
`timescale 1ns/100ps
`default_nettype none

module temporizador_nota import jogo_ritmo_pkg::*; #(
    parameter int TICKS_POR_BATIDA = 50000000
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     zera_tempo,
    input  logic                     conta_tempo,
    input  logic [$bits(duracao_t):0] limite,
    output logic                     fim_tempo,
    output logic                     metro
);

    localparam int LARGURA_TICK = (TICKS_POR_BATIDA > 1) ? $clog2(TICKS_POR_BATIDA) : 1;

    logic [LARGURA_TICK-1:0]   ticks;
    logic [$bits(duracao_t):0] batidas;

    // Ultimo ciclo da batida atual
    assign metro = conta_tempo && (ticks == LARGURA_TICK'(TICKS_POR_BATIDA - 1));

    // Fim quando a batida que termina agora completa o limite
    assign fim_tempo = metro && ((batidas + 1'b1) == limite);

    always_ff @(posedge clock) begin
        if (reset || zera_tempo) begin
            ticks   <= '0;
            batidas <= '0;
        end else if (conta_tempo) begin
            if (metro) begin
                ticks   <= '0;
                batidas <= batidas + 1'b1;
            end else begin
                ticks <= ticks + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/memoria_musica.sv ====
`timescale 1ns/100ps
`default_nettype none

module memoria_musica import jogo_ritmo_pkg::*; #(
    parameter int MUSICA = 16
) (
    input  logic [3:0] endereco,
    output nota_t      nota,
    output duracao_t   duracao
);

    // Palavra da musica: nota nos bits altos, duracao nos baixos
    logic [3:0] palavra;

    always_comb begin
        case (endereco)
            4'h0:    palavra = 4'b01_01;
            4'h1:    palavra = 4'b00_10;
            4'h2:    palavra = 4'b11_01;
            4'h3:    palavra = 4'b10_10;
            4'h4:    palavra = 4'b01_01;
            4'h5:    palavra = 4'b00_10;
            4'h6:    palavra = 4'b11_01;
            4'h7:    palavra = 4'b10_10;
            4'h8:    palavra = 4'b01_01;
            4'h9:    palavra = 4'b00_10;
            4'ha:    palavra = 4'b11_01;
            4'hb:    palavra = 4'b10_10;
            4'hc:    palavra = 4'b01_01;
            4'hd:    palavra = 4'b00_10;
            4'he:    palavra = 4'b11_01;
            default: palavra = 4'b10_10;
        endcase

        // Fora da musica
        if (int'(endereco) >= MUSICA) begin
            palavra = 4'b00_01;
        end
    end

    assign nota    = palavra[3:2];
    assign duracao = palavra[1:0];

endmodule

`default_nettype wire

// ==== source/fluxo_dados.sv ====
`timescale 1ns/100ps
`default_nettype none

module fluxo_dados import jogo_ritmo_pkg::*; #(
    parameter int MUSICA = 16,
    parameter int ERRO   = 3
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [3:0]                botoes,
    input  logic                      zera_rodada,
    input  logic                      conta_rodada,
    input  logic                      zera_endereco,
    input  logic                      conta_endereco,
    input  logic                      zera_erros,
    input  logic                      conta_erro,
    input  logic                      apresenta,
    input  logic                      toca,
    output logic                      nota_feita,
    output logic                      nota_correta,
    output logic                      endereco_igual_rodada,
    output logic                      fim_musica,
    output logic                      erros_max,
    output logic [$bits(duracao_t):0] limite_tempo,
    output logic [3:0]                leds,
    output logic                      pulso_buzzer,
    output logic [3:0]                db_rodada
);

    logic [3:0]      botoes_reg;
    logic [3:0]      botoes_ant;
    nota_t           nota_botao;
    nota_t           nota_musica;
    duracao_t        duracao_musica;
    logic [4:0]      rodada;
    logic [3:0]      endereco;
    logic [ERRO-1:0] erros;

    memoria_musica #(
        .MUSICA ( MUSICA )
    ) memoria_musica (
        .endereco ( endereco       ),
        .nota     ( nota_musica    ),
        .duracao  ( duracao_musica )
    );

    // Botoes registrados duas vezes para detectar a borda
    always_ff @(posedge clock) begin
        if (reset) begin
            botoes_reg <= '0;
            botoes_ant <= '0;
        end else begin
            botoes_reg <= botoes;
            botoes_ant <= botoes_reg;
        end
    end

    assign nota_feita = |(botoes_reg & ~botoes_ant);

    always_comb begin
        case (botoes_reg)
            4'b0010: nota_botao = 2'd1;
            4'b0100: nota_botao = 2'd2;
            4'b1000: nota_botao = 2'd3;
            default: nota_botao = 2'd0;
        endcase
    end

    assign nota_correta = (nota_botao == nota_musica);

    // Contadores de rodada, endereco e erros
    always_ff @(posedge clock) begin
        if (reset || zera_rodada) begin
            rodada <= '0;
        end else if (conta_rodada) begin
            rodada <= rodada + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || zera_endereco) begin
            endereco <= '0;
        end else if (conta_endereco) begin
            endereco <= endereco + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || zera_erros) begin
            erros <= '0;
        end else if (conta_erro) begin
            erros <= erros + 1'b1;
        end
    end

    assign endereco_igual_rodada = ({1'b0, endereco} == (rodada - 5'd1));
    assign fim_musica            = (rodada == 5'(MUSICA));
    assign erros_max             = &erros;

    // Jogador ganha uma batida a mais que a nota
    assign limite_tempo = apresenta ? {1'b0, duracao_musica}
                                    : {1'b0, duracao_musica} + 3'd1;

    assign leds = apresenta ? (4'b0001 << nota_musica) : 4'b0000;

    // Alinha o pulso com o primeiro ciclo do LED
    always_ff @(posedge clock) begin
        if (reset) begin
            pulso_buzzer <= 1'b0;
        end else begin
            pulso_buzzer <= toca;
        end
    end

    assign db_rodada = rodada[3:0];

endmodule

`default_nettype wire

// ==== source/unidade_controle.sv ====
`timescale 1ns/100ps
`default_nettype none

module unidade_controle import jogo_ritmo_pkg::*; #(
    parameter int ERRO = 3
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    iniciar,
    input  logic    nota_feita,
    input  logic    nota_correta,
    input  logic    endereco_igual_rodada,
    input  logic    fim_musica,
    input  logic    erros_max,
    input  logic    fim_tempo,
    output logic    zera_rodada,
    output logic    conta_rodada,
    output logic    zera_endereco,
    output logic    conta_endereco,
    output logic    zera_erros,
    output logic    conta_erro,
    output logic    apresenta,
    output logic    toca,
    output logic    zera_tempo,
    output logic    conta_tempo,
    output logic    ganhou,
    output logic    perdeu,
    output logic    vez_jogador,
    output estado_t db_estado
);

    // Contador de um bit: o primeiro erro ja encerra o jogo
    localparam bit ERRO_UNICO = (ERRO == 1);

    estado_t estado;
    estado_t proximo;

    always_ff @(posedge clock) begin
        if (reset) begin
            estado <= e_inicial;
        end else begin
            estado <= proximo;
        end
    end

    always_comb begin
        proximo = estado;
        case (estado)
            e_inicial:        if (iniciar) proximo = e_preparacao;
            e_preparacao:     proximo = e_proxima_rodada;
            e_proxima_rodada: proximo = e_inicia_rodada;
            // Contagem de erros ja atualizada aqui
            e_inicia_rodada:  proximo = erros_max ? e_perdeu : e_intervalo;
            e_intervalo:      proximo = e_mostra_nota;
            e_mostra_nota: begin
                if (fim_tempo) begin
                    proximo = endereco_igual_rodada ? e_inicia_jogada : e_proxima_mostra;
                end
            end
            e_proxima_mostra: proximo = e_mostra_nota;
            e_inicia_jogada:  proximo = e_espera_jogada;
            e_espera_jogada: begin
                // Jogada tem prioridade sobre o fim da janela
                if (nota_feita) begin
                    proximo = nota_correta ? e_compara : e_erro;
                end else if (fim_tempo) begin
                    proximo = e_erro;
                end
            end
            e_compara: begin
                if (!endereco_igual_rodada) begin
                    proximo = e_proxima_jogada;
                end else if (fim_musica) begin
                    proximo = e_ganhou;
                end else begin
                    proximo = e_proxima_rodada;
                end
            end
            e_proxima_jogada: proximo = e_espera_jogada;
            e_erro:           proximo = ERRO_UNICO ? e_perdeu : e_inicia_rodada;
            e_ganhou:         if (iniciar) proximo = e_preparacao;
            e_perdeu:         if (iniciar) proximo = e_preparacao;
            default:          proximo = e_inicial;
        endcase
    end

    // Saidas de Moore
    assign zera_rodada    = (estado == e_preparacao);
    assign conta_rodada   = (estado == e_proxima_rodada);
    assign zera_erros     = (estado == e_preparacao);
    assign conta_erro     = (estado == e_erro);
    assign zera_endereco  = (estado == e_preparacao) || (estado == e_inicia_rodada)
                         || (estado == e_inicia_jogada);
    assign conta_endereco = (estado == e_proxima_mostra) || (estado == e_proxima_jogada);
    assign apresenta      = (estado == e_mostra_nota);
    assign toca           = (estado == e_intervalo) || (estado == e_proxima_mostra);
    assign conta_tempo    = (estado == e_mostra_nota) || (estado == e_espera_jogada);
    assign zera_tempo     = (estado == e_preparacao) || (estado == e_inicia_rodada)
                         || (estado == e_intervalo) || (estado == e_proxima_mostra)
                         || (estado == e_inicia_jogada) || (estado == e_proxima_jogada);

    assign vez_jogador = (estado == e_inicia_jogada) || (estado == e_espera_jogada)
                      || (estado == e_compara) || (estado == e_proxima_jogada);
    assign ganhou      = (estado == e_ganhou);
    assign perdeu      = (estado == e_perdeu);

    assign db_estado = estado;

endmodule

`default_nettype wire

// ==== source/circuito_principal.sv ====
`timescale 1ns/100ps
`default_nettype none

module circuito_principal import jogo_ritmo_pkg::*; #(
    parameter int TICKS_POR_BATIDA = 50000000,
    parameter int MUSICA           = 16,
    parameter int ERRO             = 3
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       iniciar,
    input  logic [3:0] botoes,

    output logic       ganhou,
    output logic       perdeu,
    output logic       vez_jogador,
    output logic [3:0] leds,
    output logic       pulso_buzzer,

    output logic       db_metro,
    output logic [6:0] db_rodada,
    output logic [6:0] db_estado
);

    // Sinais de controle
    logic zera_rodada, conta_rodada, zera_endereco, conta_endereco;
    logic zera_erros, conta_erro, apresenta, toca;
    logic zera_tempo, conta_tempo;

    // Sinais de condicao
    logic nota_feita, nota_correta, endereco_igual_rodada;
    logic fim_musica, erros_max, fim_tempo;
    logic [$bits(duracao_t):0] limite_tempo;

    // Valores dos displays
    logic [3:0] s_db_rodada;
    estado_t    s_db_estado;

    fluxo_dados #(
        .MUSICA ( MUSICA ),
        .ERRO   ( ERRO   )
    ) fluxo_dados (
        .clock                 ( clock                 ),
        .reset                 ( reset                 ),
        .botoes                ( botoes                ),
        .zera_rodada           ( zera_rodada           ),
        .conta_rodada          ( conta_rodada          ),
        .zera_endereco         ( zera_endereco         ),
        .conta_endereco        ( conta_endereco        ),
        .zera_erros            ( zera_erros            ),
        .conta_erro            ( conta_erro            ),
        .apresenta             ( apresenta             ),
        .toca                  ( toca                  ),
        .nota_feita            ( nota_feita            ),
        .nota_correta          ( nota_correta          ),
        .endereco_igual_rodada ( endereco_igual_rodada ),
        .fim_musica            ( fim_musica            ),
        .erros_max             ( erros_max             ),
        .limite_tempo          ( limite_tempo          ),
        .leds                  ( leds                  ),
        .pulso_buzzer          ( pulso_buzzer          ),
        .db_rodada             ( s_db_rodada           )
    );

    unidade_controle #(
        .ERRO ( ERRO )
    ) unidade_controle (
        .clock                 ( clock                 ),
        .reset                 ( reset                 ),
        .iniciar               ( iniciar               ),
        .nota_feita            ( nota_feita            ),
        .nota_correta          ( nota_correta          ),
        .endereco_igual_rodada ( endereco_igual_rodada ),
        .fim_musica            ( fim_musica            ),
        .erros_max             ( erros_max             ),
        .fim_tempo             ( fim_tempo             ),
        .zera_rodada           ( zera_rodada           ),
        .conta_rodada          ( conta_rodada          ),
        .zera_endereco         ( zera_endereco         ),
        .conta_endereco        ( conta_endereco        ),
        .zera_erros            ( zera_erros            ),
        .conta_erro            ( conta_erro            ),
        .apresenta             ( apresenta             ),
        .toca                  ( toca                  ),
        .zera_tempo            ( zera_tempo            ),
        .conta_tempo           ( conta_tempo           ),
        .ganhou                ( ganhou                ),
        .perdeu                ( perdeu                ),
        .vez_jogador           ( vez_jogador           ),
        .db_estado             ( s_db_estado           )
    );

    temporizador_nota #(
        .TICKS_POR_BATIDA ( TICKS_POR_BATIDA )
    ) temporizador_nota (
        .clock       ( clock        ),
        .reset       ( reset        ),
        .zera_tempo  ( zera_tempo   ),
        .conta_tempo ( conta_tempo  ),
        .limite      ( limite_tempo ),
        .fim_tempo   ( fim_tempo    ),
        .metro       ( db_metro     )
    );

    hexa7seg display_rodada (
        .hexa    ( s_db_rodada ),
        .display ( db_rodada   )
    );

    hexa7seg display_estado (
        .hexa    ( s_db_estado ),
        .display ( db_estado   )
    );

endmodule

`default_nettype wire

// ==== verif/circuito_principal_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module circuito_principal_tb import jogo_ritmo_pkg::*; ();

    localparam int TICKS  = 4;
    localparam int MUSICA = 4;
    localparam int ERRO   = 2;
    localparam int LIMITE = 200;

    // Modo de jogar uma rodada
    localparam int CERTA  = 0;
    localparam int ERRADA = 1;
    localparam int TEMPO  = 2;

    logic        clock;
    logic        reset;
    logic        iniciar;
    logic [3:0]  botoes;
    logic        ganhou;
    logic        perdeu;
    logic        vez_jogador;
    logic [3:0]  leds;
    logic        pulso_buzzer;
    logic        db_metro;
    logic [6:0]  db_rodada;
    logic [6:0]  db_estado;

    logic [15:0] lfsr;
    int          rodada_esperada;

    // Estado do processo que confere a apresentacao
    logic [3:0]  leds_ant;
    logic        vez_ant;
    int          indice;
    int          ciclos_led;

    circuito_principal #(
        .TICKS_POR_BATIDA ( TICKS  ),
        .MUSICA           ( MUSICA ),
        .ERRO             ( ERRO   )
    ) dut0 (
        .clock        ( clock        ),
        .reset        ( reset        ),
        .iniciar      ( iniciar      ),
        .botoes       ( botoes       ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       ),
        .vez_jogador  ( vez_jogador  ),
        .leds         ( leds         ),
        .pulso_buzzer ( pulso_buzzer ),
        .db_metro     ( db_metro     ),
        .db_rodada    ( db_rodada    ),
        .db_estado    ( db_estado    )
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic int nota_esperada(input int a);
        return (3 * a + 1) % 4;
    endfunction

    function automatic int duracao_esperada(input int a);
        return (a % 2 == 0) ? 1 : 2;
    endfunction

    // Segmentos gfedcba ativos em baixo
    function automatic logic [6:0] segmentos(input logic [3:0] h);
        case (h)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'ha:    return 7'b0001000;
            4'hb:    return 7'b0000011;
            4'hc:    return 7'b1000110;
            4'hd:    return 7'b0100001;
            4'he:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    function automatic logic [15:0] lfsr_proximo(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic sorteia(input int n, output int valor);
        valor = 0;
        for (int k = 0; k < n; k++) begin
            valor = (valor << 1) | int'(lfsr[0]);
            lfsr  = lfsr_proximo(lfsr);
        end
    endtask

    task automatic confere(input string nome, input int esperado, input int obtido);
        if (esperado != obtido) begin
            $display("error: %s expected %0d actual %0d", nome, esperado, obtido);
            $display("TEST RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic estouro(input string o_que);
        $display("timeout while waiting for %s", o_que);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic espera_estado(input estado_t e, input int limite, input string o_que);
        int ciclos;
        ciclos = 0;
        @(negedge clock);
        while (db_estado != segmentos(e)) begin
            ciclos++;
            if (ciclos > limite) begin
                estouro(o_que);
            end else begin
                @(negedge clock);
            end
        end
    endtask

    // Conta os ciclos ainda no estado e
    task automatic espera_troca(input estado_t e, input int limite, output int ciclos);
        ciclos = 0;
        while (db_estado == segmentos(e)) begin
            ciclos++;
            if (ciclos > limite) begin
                estouro("the state to change");
            end else begin
                @(negedge clock);
            end
        end
    endtask

    task automatic pressiona(input int nota, input estado_t depois);
        int segura;
        int ciclos;
        @(posedge clock);
        botoes <= 4'b0001 << nota;
        @(negedge clock);
        espera_troca(e_espera_jogada, LIMITE, ciclos);
        // Borda um ciclo depois, julgamento no seguinte
        confere("press response", 2, ciclos);
        confere("state after press", segmentos(depois), db_estado);
        sorteia(1, segura);
        repeat (segura + 1) @(posedge clock);
        botoes <= 4'b0000;
    endtask

    task automatic joga_rodada(input int r, input int falha, input int pos);
        int v;
        int errada;
        int ciclos;
        bit feito;
        feito = 1'b0;
        for (int i = 0; i < r && !feito; i++) begin
            espera_estado(e_espera_jogada, LIMITE, "the player's turn");
            if (falha == TEMPO && i == pos) begin
                espera_troca(e_espera_jogada, (duracao_esperada(i) + 2) * TICKS, ciclos);
                confere("press window", (duracao_esperada(i) + 1) * TICKS, ciclos);
                confere("state after timeout", segmentos(e_erro), db_estado);
                feito = 1'b1;
            end else if (falha == ERRADA && i == pos) begin
                sorteia(2, v);
                errada = (nota_esperada(i) + 1 + v % 3) % 4;
                pressiona(errada, e_erro);
                feito = 1'b1;
            end else begin
                pressiona(nota_esperada(i), e_compara);
            end
        end
    endtask

    task automatic inicia_jogo();
        @(posedge clock);
        iniciar <= 1'b1;
        @(posedge clock);
        iniciar <= 1'b0;
        espera_estado(e_preparacao, 4, "the game start");
        confere("ganhou at start", 0, ganhou);
        confere("perdeu at start", 0, perdeu);
    endtask

    task automatic mantem_resultado(input int g, input int p);
        repeat (20) begin
            @(negedge clock);
            confere("ganhou held", g, ganhou);
            confere("perdeu held", p, perdeu);
            confere("vez_jogador after end", 0, vez_jogador);
            confere("leds after end", 0, leds);
            confere("metro after end", 0, db_metro);
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            leds_ant   = 4'b0000;
            vez_ant    = 1'b0;
            indice     = 0;
            ciclos_led = 0;
        end else begin
            if (leds != 4'b0000 && leds_ant == 4'b0000) begin
                confere("presented note", 1 << nota_esperada(indice), leds);
                confere("round display", segmentos(rodada_esperada), db_rodada);
                indice     = indice + 1;
                ciclos_led = 0;
            end
            if (leds != 4'b0000 && leds_ant != 4'b0000) begin
                confere("steady note", leds_ant, leds);
            end
            if (leds != 4'b0000) begin
                ciclos_led = ciclos_led + 1;
                // Pulso no ultimo ciclo de cada batida
                confere("beat pulse", (ciclos_led % TICKS) == 0, db_metro);
            end
            if (leds == 4'b0000 && leds_ant != 4'b0000) begin
                confere("note length", duracao_esperada(indice - 1) * TICKS, ciclos_led);
            end
            confere("buzzer strobe", (leds != 4'b0000 && leds_ant == 4'b0000), pulso_buzzer);
            // Nova vez do jogador fecha a apresentacao
            if (vez_jogador && !vez_ant) begin
                confere("notes per round", rodada_esperada, indice);
                indice = 0;
            end
            leds_ant = leds;
            vez_ant  = vez_jogador;
        end
    end

    initial begin
        reset           = 1'b1;
        iniciar         = 1'b0;
        botoes          = 4'b0000;
        lfsr            = 16'd6427;
        rodada_esperada = 0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        confere("ganhou after reset", 0, ganhou);
        confere("perdeu after reset", 0, perdeu);
        confere("vez_jogador after reset", 0, vez_jogador);
        confere("leds after reset", 0, leds);
        confere("buzzer after reset", 0, pulso_buzzer);
        confere("metro after reset", 0, db_metro);
        confere("state after reset", segmentos(e_inicial), db_estado);

        // Vitoria com um erro de nota e um de tempo
        rodada_esperada <= 1;
        inicia_jogo();
        joga_rodada(1, CERTA, 0);
        rodada_esperada <= 2;
        joga_rodada(2, ERRADA, 1);
        joga_rodada(2, CERTA, 0);
        rodada_esperada <= 3;
        joga_rodada(3, TEMPO, 2);
        joga_rodada(3, CERTA, 0);
        rodada_esperada <= 4;
        joga_rodada(4, CERTA, 0);
        espera_estado(e_ganhou, LIMITE, "the win");
        mantem_resultado(1, 0);

        // Terceiro erro leva a derrota
        rodada_esperada <= 1;
        inicia_jogo();
        joga_rodada(1, ERRADA, 0);
        joga_rodada(1, ERRADA, 0);
        joga_rodada(1, TEMPO, 0);
        espera_estado(e_perdeu, LIMITE, "the loss");
        mantem_resultado(0, 1);

        rodada_esperada <= 1;
        inicia_jogo();
        joga_rodada(1, CERTA, 0);
        rodada_esperada <= 2;
        espera_estado(e_espera_jogada, LIMITE, "the second round");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== jogo_ritmo.f ====
source/jogo_ritmo_pkg.sv
source/hexa7seg.sv
source/temporizador_nota.sv
source/memoria_musica.sv
source/fluxo_dados.sv
source/unidade_controle.sv
source/circuito_principal.sv
verif/circuito_principal_tb.sv

// ==== Bender.yml ====
package:
  name: jogo_ritmo

sources:
  - source/jogo_ritmo_pkg.sv
  - source/hexa7seg.sv
  - source/temporizador_nota.sv
  - source/memoria_musica.sv
  - source/fluxo_dados.sv
  - source/unidade_controle.sv
  - source/circuito_principal.sv
  - target: test
    files:
      - verif/circuito_principal_tb.sv
